// File: common/cpu_pkg.sv
// cpu package: widths, instruction fields, opcodes and ALU operations of the core
package cpu_pkg;

    localparam int XLEN       = 32;  // data and instruction width
    localparam int PC_W       = 8;   // pc counts instructions
    localparam int REG_ADDR_W = 5;

    // instruction field positions
    localparam int OPCODE_LSB = 26;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int SHAMT_LSB  = 6;
    localparam int FUNCT_LSB  = 0;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_SLL = 6'h00;  // all-zero word lands here, rd 0
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL
    } alu_op_t;

endpackage

// File: logic/fetch_stage.sv
// fetch stage: program counter with user load, stall hold and increment
`timescale 1ns/100ps

module fetch_stage import cpu_pkg::*;
(
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    input  logic            load,
    input  logic [PC_W-1:0] pc_val,
    input  logic            stall,
    output logic [PC_W-1:0] pc
);

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc <= '0;
        end
        else if (load)
        begin
            pc <= pc_val;  // user load wins over stall
        end
        else if (!stall)
        begin
            pc <= pc + 1'b1;
        end
    end

    a_pc_known: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !$isunknown(pc))
        else $error("pc unknown after reset");

endmodule

// File: decode/register_file.sv
// register file: 32 words, write-through reads and a probe port
`timescale 1ns/100ps

module register_file import cpu_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic [REG_ADDR_W-1:0] rs_addr,
    input  logic [REG_ADDR_W-1:0] rt_addr,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_addr,
    input  logic [XLEN-1:0]       wr_data,
    input  logic [REG_ADDR_W-1:0] probe_addr,
    output logic [XLEN-1:0]       rs_data,
    output logic [XLEN-1:0]       rt_data,
    output logic [XLEN-1:0]       probe_data
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write-back is visible to decode
    assign rs_data    = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data    = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];
    assign probe_data = regs[probe_addr];

    // decode masks r0 writes so r0 keeps its reset value
    a_r0_zero: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (rs_addr != '0 || rs_data == '0) && (rt_addr != '0 || rt_data == '0)
        && (probe_addr != '0 || probe_data == '0))
        else $error("register zero reads nonzero");

endmodule

// File: decode/decode_stage.sv
// decode stage: instruction register, control decode, immediate and operand forwarding
`timescale 1ns/100ps

module decode_stage import cpu_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic [XLEN-1:0]       instr,
    input  logic                  stall,
    input  logic                  fwd_rs,
    input  logic                  fwd_rt,
    input  logic [XLEN-1:0]       mem_result,
    input  logic                  wb_write,
    input  logic [REG_ADDR_W-1:0] wb_dest,
    input  logic [XLEN-1:0]       wb_data,
    input  logic [REG_ADDR_W-1:0] probe_addr,
    output logic [REG_ADDR_W-1:0] rs,
    output logic [REG_ADDR_W-1:0] rt,
    output logic                  reads_rt,
    output logic [XLEN-1:0]       op_a,
    output logic [XLEN-1:0]       op_b,
    output logic [XLEN-1:0]       imm,
    output logic [REG_ADDR_W-1:0] dest,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  alu_src_imm,
    output alu_op_t               alu_op,
    output logic [4:0]            shamt,
    output logic [XLEN-1:0]       probe_data
);

    logic [XLEN-1:0] instr_q;
    logic [5:0]      opcode;
    logic [5:0]      funct;
    logic            is_valid;
    logic            use_rd;
    logic            wr_ctl;
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            instr_q <= '0;  // nop
        else if (!stall)
            instr_q <= instr;
    end

    assign opcode = instr_q[OPCODE_LSB +: 6];
    assign funct  = instr_q[FUNCT_LSB +: 6];

    always_comb
    begin
        is_valid    = 1'b0;
        use_rd      = 1'b0;
        wr_ctl      = 1'b0;
        reads_rt    = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        alu_src_imm = 1'b0;
        alu_op      = ALU_ADD;
        case (opcode)
            OP_RTYPE:
            begin
                is_valid = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLL:  alu_op = ALU_SLL;
                    default: is_valid = 1'b0;  // unknown funct is a nop
                endcase
                use_rd   = is_valid;
                wr_ctl   = is_valid;
                reads_rt = is_valid;
            end
            OP_ADDI:
            begin
                is_valid    = 1'b1;
                wr_ctl      = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                is_valid    = 1'b1;
                wr_ctl      = 1'b1;
                mem_read    = 1'b1;
                alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                is_valid    = 1'b1;
                reads_rt    = 1'b1;  // store data
                mem_write   = 1'b1;
                alu_src_imm = 1'b1;
            end
            default:
            begin
                is_valid = 1'b0;
            end
        endcase
    end

    // a nop reports r0 as its source so the hazard unit ignores it
    assign rs        = is_valid ? instr_q[RS_LSB +: REG_ADDR_W] : '0;
    assign rt        = instr_q[RT_LSB +: REG_ADDR_W];
    assign dest      = use_rd ? instr_q[RD_LSB +: REG_ADDR_W] : rt;
    assign reg_write = wr_ctl && (dest != '0);  // r0 writes count as no write
    assign imm       = {{(XLEN-16){instr_q[15]}}, instr_q[15:0]};
    assign shamt     = instr_q[SHAMT_LSB +: 5];

    register_file regfile_i (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .rs_addr    (rs),
        .rt_addr    (rt),
        .wr_en      (wb_write),
        .wr_addr    (wb_dest),
        .wr_data    (wb_data),
        .probe_addr (probe_addr),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .probe_data (probe_data)
    );

    assign op_a = fwd_rs ? mem_result : rs_data;  // alu result one stage ahead
    assign op_b = fwd_rt ? mem_result : rt_data;

endmodule

// File: logic/hazard_unit.sv
// hazard unit: dependency stall and memory-to-decode forward detection
`timescale 1ns/100ps

module hazard_unit import cpu_pkg::*;
(
    input  logic [REG_ADDR_W-1:0] rs,
    input  logic [REG_ADDR_W-1:0] rt,
    input  logic                  reads_rt,
    input  logic [REG_ADDR_W-1:0] ex_dest,
    input  logic                  ex_write,
    input  logic [REG_ADDR_W-1:0] mem_dest,
    input  logic                  mem_write_reg,
    input  logic                  mem_load,
    output logic                  stall,
    output logic                  fwd_rs,
    output logic                  fwd_rt
);

    logic mem_alu_write;
    logic rs_ex;
    logic rt_ex;
    logic rs_ld;
    logic rt_ld;

    // nonzero source matching an active destination
    function automatic logic hit(input logic [REG_ADDR_W-1:0] src,
                                 input logic [REG_ADDR_W-1:0] dst,
                                 input logic                  en);
        hit = en && (src != '0) && (src == dst);
    endfunction

    assign mem_alu_write = mem_write_reg && !mem_load;

    assign rs_ex = hit(rs, ex_dest, ex_write);  // result not computed yet
    assign rt_ex = reads_rt && hit(rt, ex_dest, ex_write);
    assign rs_ld = hit(rs, mem_dest, mem_load);  // load data not back yet
    assign rt_ld = reads_rt && hit(rt, mem_dest, mem_load);

    assign stall  = rs_ex || rt_ex || rs_ld || rt_ld;
    assign fwd_rs = hit(rs, mem_dest, mem_alu_write);
    assign fwd_rt = reads_rt && hit(rt, mem_dest, mem_alu_write);

    // the memory stage never presents an r0 write as a forward source
    always_comb
    begin
        a_no_fwd_r0: assert #0 (!mem_write_reg || mem_dest != '0)
            else $error("memory stage presents a write to register zero");
    end

endmodule

// File: logic/execute_stage.sv
// execute stage: pipeline register and ALU
`timescale 1ns/100ps

module execute_stage import cpu_pkg::*;
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  stall,
    input  logic [XLEN-1:0]       op_a,
    input  logic [XLEN-1:0]       op_b,
    input  logic [XLEN-1:0]       imm,
    input  logic [REG_ADDR_W-1:0] dest,
    input  logic                  reg_write,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  alu_src_imm,
    input  alu_op_t               alu_op,
    input  logic [4:0]            shamt,
    output logic [XLEN-1:0]       alu_result,
    output logic [XLEN-1:0]       store_data,
    output logic [REG_ADDR_W-1:0] ex_dest,
    output logic                  ex_write,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write
);

    logic [XLEN-1:0] a_q;
    logic [XLEN-1:0] b_q;
    logic [XLEN-1:0] imm_q;
    logic            src_imm_q;
    alu_op_t         alu_op_q;
    logic [4:0]      shamt_q;
    logic [XLEN-1:0] alu_b;

    // control levels, a bubble goes in while decode is stalled
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            ex_write     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end
        else
        begin
            ex_write     <= reg_write && !stall;
            ex_mem_read  <= mem_read && !stall;
            ex_mem_write <= mem_write && !stall;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        a_q       <= op_a;
        b_q       <= op_b;
        imm_q     <= imm;
        ex_dest   <= dest;
        src_imm_q <= alu_src_imm;
        alu_op_q  <= alu_op;
        shamt_q   <= shamt;
    end

    assign alu_b      = src_imm_q ? imm_q : b_q;
    assign store_data = b_q;  // rt value for sw

    always_comb
    begin
        case (alu_op_q)
            ALU_ADD: alu_result = a_q + alu_b;  // wraps
            ALU_SUB: alu_result = a_q - alu_b;
            ALU_AND: alu_result = a_q & alu_b;
            ALU_OR:  alu_result = a_q | alu_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(a_q) < $signed(alu_b)};
            ALU_SLL: alu_result = b_q << shamt_q;  // shifts rt
            default: alu_result = '0;
        endcase
    end

endmodule

// File: logic/memory_stage.sv
// memory stage: memory register, word-addressed data memory and write-back register
`timescale 1ns/100ps

module memory_stage import cpu_pkg::*;
#(
    parameter int DMEM_ADDR_W = 6
)
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic [XLEN-1:0]       alu_result,
    input  logic [XLEN-1:0]       store_data,
    input  logic [REG_ADDR_W-1:0] ex_dest,
    input  logic                  ex_write,
    input  logic                  ex_mem_read,
    input  logic                  ex_mem_write,
    output logic [XLEN-1:0]       mem_result,
    output logic [REG_ADDR_W-1:0] mem_dest,
    output logic                  mem_write_reg,
    output logic                  mem_load,
    output logic                  wb_write,
    output logic [REG_ADDR_W-1:0] wb_dest,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0]        dmem [2**DMEM_ADDR_W];
    logic [XLEN-1:0]        store_q;
    logic                   mem_store;
    logic [DMEM_ADDR_W-1:0] word_addr;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            mem_write_reg <= 1'b0;
            mem_load      <= 1'b0;
            mem_store     <= 1'b0;
            wb_write      <= 1'b0;
        end
        else
        begin
            mem_write_reg <= ex_write;
            mem_load      <= ex_mem_read;
            mem_store     <= ex_mem_write;
            wb_write      <= mem_write_reg;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_result <= alu_result;
        store_q    <= store_data;
        mem_dest   <= ex_dest;
        wb_dest    <= mem_dest;
        wb_data    <= mem_load ? dmem[word_addr] : mem_result;  // load data or alu
    end

    assign word_addr = mem_result[2 +: DMEM_ADDR_W];  // byte offset bits ignored

    always_ff @(posedge SYS_clk)
    begin
        if (mem_store)
            dmem[word_addr] <= store_q;
    end

    a_rd_wr_excl: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_load && mem_store))
        else $error("data memory read and write in the same cycle");

endmodule

// File: logic/cpu_top.sv
// cpu top: five-stage pipeline with external instruction memory and register probe
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*;
#(
    parameter int DMEM_ADDR_W = 6
)
(
    input  logic                  SYS_clk,
    input  logic                  SYS_reset,
    input  logic                  load,
    input  logic [PC_W-1:0]       pc_val,
    input  logic [XLEN-1:0]       instr,
    input  logic [REG_ADDR_W-1:0] probe_addr,
    output logic [PC_W-1:0]       pc,
    output logic [XLEN-1:0]       probe_data
);

    logic                  stall;
    logic                  fwd_rs;
    logic                  fwd_rt;
    logic [REG_ADDR_W-1:0] rs;
    logic [REG_ADDR_W-1:0] rt;
    logic                  reads_rt;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] dest;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  alu_src_imm;
    alu_op_t               alu_op;
    logic [4:0]            shamt;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       store_data;
    logic [REG_ADDR_W-1:0] ex_dest;
    logic                  ex_write;
    logic                  ex_mem_read;
    logic                  ex_mem_write;
    logic [XLEN-1:0]       mem_result;
    logic [REG_ADDR_W-1:0] mem_dest;
    logic                  mem_write_reg;
    logic                  mem_load;
    logic                  wb_write;
    logic [REG_ADDR_W-1:0] wb_dest;
    logic [XLEN-1:0]       wb_data;

    fetch_stage fetch_i (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .load      (load),
        .pc_val    (pc_val),
        .stall     (stall),
        .pc        (pc)
    );

    decode_stage decode_i (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .instr       (instr),
        .stall       (stall),
        .fwd_rs      (fwd_rs),
        .fwd_rt      (fwd_rt),
        .mem_result  (mem_result),
        .wb_write    (wb_write),
        .wb_dest     (wb_dest),
        .wb_data     (wb_data),
        .probe_addr  (probe_addr),
        .rs          (rs),
        .rt          (rt),
        .reads_rt    (reads_rt),
        .op_a        (op_a),
        .op_b        (op_b),
        .imm         (imm),
        .dest        (dest),
        .reg_write   (reg_write),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .alu_src_imm (alu_src_imm),
        .alu_op      (alu_op),
        .shamt       (shamt),
        .probe_data  (probe_data)
    );

    hazard_unit hazard_i (
        .rs            (rs),
        .rt            (rt),
        .reads_rt      (reads_rt),
        .ex_dest       (ex_dest),
        .ex_write      (ex_write),
        .mem_dest      (mem_dest),
        .mem_write_reg (mem_write_reg),
        .mem_load      (mem_load),
        .stall         (stall),
        .fwd_rs        (fwd_rs),
        .fwd_rt        (fwd_rt)
    );

    execute_stage execute_i (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .stall        (stall),
        .op_a         (op_a),
        .op_b         (op_b),
        .imm          (imm),
        .dest         (dest),
        .reg_write    (reg_write),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .alu_src_imm  (alu_src_imm),
        .alu_op       (alu_op),
        .shamt        (shamt),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .ex_dest      (ex_dest),
        .ex_write     (ex_write),
        .ex_mem_read  (ex_mem_read),
        .ex_mem_write (ex_mem_write)
    );

    memory_stage #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) memory_i (
        .SYS_clk       (SYS_clk),
        .SYS_reset     (SYS_reset),
        .alu_result    (alu_result),
        .store_data    (store_data),
        .ex_dest       (ex_dest),
        .ex_write      (ex_write),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .mem_result    (mem_result),
        .mem_dest      (mem_dest),
        .mem_write_reg (mem_write_reg),
        .mem_load      (mem_load),
        .wb_write      (wb_write),
        .wb_dest       (wb_dest),
        .wb_data       (wb_data)
    );

endmodule

// File: bench/cpu_ref_model.svh
// reference model: architectural registers, data memory, instruction semantics and xorshift
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

logic [XLEN-1:0] model_regs [32];
logic [XLEN-1:0] model_mem [2**DMEM_ADDR_W];  // persists across resets like the DUT memory
logic [31:0]     rng_state = 32'he7ae_c8e9;

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic model_clear_regs();
    for (int i = 0; i < 32; i++)
        model_regs[i] = '0;
endtask

// one instruction, executed in program order with no pipeline
task automatic model_exec(input logic [31:0] w);
    logic [5:0]      op;
    logic [5:0]      fn;
    logic [4:0]      rs;
    logic [4:0]      rt;
    logic [4:0]      rd;
    logic [4:0]      sh;
    logic [4:0]      dst;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] res;
    logic            wr;
    op   = w[31:26];
    rs   = w[25:21];
    rt   = w[20:16];
    rd   = w[15:11];
    sh   = w[10:6];
    fn   = w[5:0];
    imm  = {{16{w[15]}}, w[15:0]};
    a    = model_regs[rs];
    b    = model_regs[rt];
    addr = a + imm;
    res  = '0;
    dst  = rd;
    wr   = 1'b0;
    case (op)
        OP_RTYPE:
        begin
            wr = 1'b1;
            case (fn)
                FN_ADD:  res = a + b;
                FN_SUB:  res = a - b;
                FN_AND:  res = a & b;
                FN_OR:   res = a | b;
                FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLL:  res = b << sh;
                default: wr = 1'b0;  // unknown funct does nothing
            endcase
        end
        OP_ADDI:
        begin
            wr  = 1'b1;
            dst = rt;
            res = a + imm;
        end
        OP_LW:
        begin
            wr  = 1'b1;
            dst = rt;
            res = model_mem[addr[DMEM_ADDR_W+1:2]];  // word bits only
        end
        OP_SW:
        begin
            model_mem[addr[DMEM_ADDR_W+1:2]] = b;
        end
        default:
        begin
            wr = 1'b0;
        end
    endcase
    if (wr && dst != 5'd0)
        model_regs[dst] = res;
endtask

`endif

// File: bench/cpu_tb.sv
// cpu testbench: directed and random programs checked register by register against a model
`timescale 1ns/100ps

module cpu_tb import cpu_pkg::*;
();

    localparam int DMEM_ADDR_W = 6;
    localparam int HALF_PERIOD = 10;  // 20 ns clock

    logic                  SYS_clk;
    logic                  SYS_reset;
    logic                  load;
    logic [PC_W-1:0]       pc_val;
    logic [XLEN-1:0]       instr;
    logic [REG_ADDR_W-1:0] probe_addr;
    logic [PC_W-1:0]       pc;
    logic [XLEN-1:0]       probe_data;

    logic [XLEN-1:0] prog_mem [2**PC_W];
    logic [PC_W:0]   prog_len;
    int              checks;
    int              errors;
    int              budget_cycles;

    `include "cpu_ref_model.svh"

    cpu_top #(
        .DMEM_ADDR_W (DMEM_ADDR_W)
    ) dut_i (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .load       (load),
        .pc_val     (pc_val),
        .instr      (instr),
        .probe_addr (probe_addr),
        .pc         (pc),
        .probe_data (probe_data)
    );

    // instruction memory returns zero past the end of the program
    assign instr = ({1'b0, pc} < prog_len) ? prog_mem[pc] : '0;

    initial
    begin
        SYS_clk = 1'b0;
        forever #HALF_PERIOD SYS_clk = ~SYS_clk;
    end

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
                                           input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        r  = next_random();
        ra = {2'b00, r[2:0]};  // eight registers give many dependencies
        rb = {2'b00, r[5:3]};
        rc = {2'b00, r[8:6]};
        case (r[31:24] % 8'd9)
            8'd0:    return r_type(FN_ADD, ra, rb, rc, 5'd0);
            8'd1:    return r_type(FN_SUB, ra, rb, rc, 5'd0);
            8'd2:    return r_type(FN_AND, ra, rb, rc, 5'd0);
            8'd3:    return r_type(FN_OR, ra, rb, rc, 5'd0);
            8'd4:    return r_type(FN_SLT, ra, rb, rc, 5'd0);
            8'd5:    return r_type(FN_SLL, ra, 5'd0, rc, r[13:9]);
            8'd6:    return i_type(OP_ADDI, ra, rb, r[24:9]);
            8'd7:    return i_type(OP_LW, ra, rb, {8'd0, r[14:9], 2'b00});
            default: return i_type(OP_SW, ra, rb, {8'd0, r[14:9], 2'b00});
        endcase
    endfunction

    task automatic start_program();
        prog_len = '0;
    endtask

    task automatic add_instr(input logic [31:0] w);
        prog_mem[prog_len[PC_W-1:0]] = w;
        prog_len = prog_len + 1'b1;
    endtask

    task automatic add_spaced(input logic [31:0] w);
        add_instr(w);
        repeat (3) add_instr(32'd0);  // producer retires before the next one decodes
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error %s: %s expected %h actual %h", name, what, exp, got);
        end
    endtask

    task automatic apply_reset();
        @(posedge SYS_clk);
        SYS_reset <= 1'b1;
        repeat (4) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
    endtask

    task automatic compare_registers(input string name);
        for (int r = 0; r < 32; r++)
        begin
            @(posedge SYS_clk);
            probe_addr <= r[4:0];
            @(negedge SYS_clk);
            check_word(name, $sformatf("r%0d", r), model_regs[r], probe_data);
        end
    endtask

    task automatic check_reset(input string name);
        budget_cycles += 40;
        start_program();  // only nops are fetched
        model_clear_regs();
        apply_reset();
        @(negedge SYS_clk);
        check_word(name, "pc", 32'd0, 32'(pc));
        compare_registers(name);
    endtask

    task automatic run_program(input string name, input logic [PC_W-1:0] start);
        budget_cycles += 3 * int'(prog_len) + 40;
        model_clear_regs();
        for (int i = int'(start); i < int'(prog_len); i++)
            model_exec(prog_mem[i]);
        apply_reset();
        load   <= (start != '0);
        pc_val <= start;
        @(posedge SYS_clk);
        load <= 1'b0;
        @(negedge SYS_clk);
        if (start != '0)
            check_word(name, "pc after load", 32'(start), 32'(pc));
        while ({1'b0, pc} < prog_len)
            @(negedge SYS_clk);
        repeat (8) @(posedge SYS_clk);  // drain the pipeline
        compare_registers(name);
    endtask

    task automatic test_memory_fill();
        start_program();
        for (int i = 0; i < 2**DMEM_ADDR_W; i++)
        begin
            add_instr(i_type(OP_ADDI, 5'd1, 5'd0, 16'h3c00 ^ 16'(i * 37)));  // distinct per word
            add_instr(i_type(OP_SW, 5'd1, 5'd0, 16'(i * 4)));
        end
        run_program("memory fill", '0);
    endtask

    task automatic test_alu();
        start_program();
        add_spaced(i_type(OP_ADDI, 1, 0, 16'hfffb));  // -5
        add_spaced(i_type(OP_ADDI, 2, 0, 16'd100));
        add_spaced(i_type(OP_ADDI, 3, 0, 16'h8000));  // most negative immediate
        add_spaced(r_type(FN_ADD, 4, 1, 2, 0));
        add_spaced(r_type(FN_SUB, 5, 1, 2, 0));
        add_spaced(r_type(FN_AND, 6, 1, 2, 0));
        add_spaced(r_type(FN_OR, 7, 1, 3, 0));
        add_spaced(r_type(FN_SLT, 8, 1, 2, 0));
        add_spaced(r_type(FN_SLT, 9, 2, 1, 0));
        add_spaced(r_type(FN_SLL, 10, 0, 1, 4));
        add_spaced(r_type(FN_SLL, 11, 0, 2, 31));
        add_spaced(i_type(OP_ADDI, 12, 2, 16'h7fff));
        run_program("alu", '0);
    endtask

    task automatic test_dependencies();
        start_program();
        add_instr(i_type(OP_ADDI, 1, 0, 16'd7));
        add_instr(r_type(FN_ADD, 2, 1, 1, 0));
        add_instr(r_type(FN_SUB, 3, 2, 1, 0));
        add_instr(r_type(FN_OR, 4, 3, 2, 0));
        add_instr(r_type(FN_AND, 5, 4, 3, 0));
        add_instr(r_type(FN_SLT, 6, 5, 4, 0));
        add_instr(r_type(FN_SLL, 7, 0, 4, 2));
        add_instr(i_type(OP_ADDI, 8, 7, 16'hfffd));
        add_instr(r_type(FN_ADD, 9, 8, 7, 0));
        add_instr(i_type(OP_ADDI, 1, 1, 16'd1));
        add_instr(r_type(FN_ADD, 1, 1, 1, 0));
        add_instr(r_type(FN_SUB, 10, 9, 1, 0));
        add_instr(i_type(OP_ADDI, 11, 10, 16'd0));
        add_instr(32'd0);
        add_instr(r_type(FN_ADD, 12, 11, 11, 0));  // producer sits in memory stage
        run_program("dependencies", '0);
    endtask

    task automatic test_load_store();
        start_program();
        add_instr(i_type(OP_ADDI, 1, 0, 16'h1234));
        add_instr(i_type(OP_ADDI, 2, 0, 16'hffb3));  // -77
        add_instr(i_type(OP_SW, 1, 0, 16'd8));
        add_instr(i_type(OP_SW, 2, 0, 16'd12));
        add_instr(i_type(OP_LW, 3, 0, 16'd8));
        add_instr(r_type(FN_ADD, 4, 3, 3, 0));  // load-use
        add_instr(i_type(OP_LW, 5, 0, 16'd12));
        add_instr(i_type(OP_SW, 5, 0, 16'd16));
        add_instr(i_type(OP_LW, 6, 0, 16'd16));
        add_instr(r_type(FN_SUB, 7, 6, 3, 0));
        add_instr(i_type(OP_ADDI, 8, 0, 16'd55));
        add_instr(i_type(OP_SW, 8, 0, 16'd252));  // last word
        add_instr(i_type(OP_LW, 9, 0, 16'd252));
        add_instr(i_type(OP_LW, 10, 0, 16'd4));
        add_instr(r_type(FN_OR, 11, 9, 10, 0));
        run_program("load store", '0);
    endtask

    task automatic test_pc_load();
        start_program();
        add_instr(32'd0);  // decoded during the load cycle
        for (int k = 1; k < 8; k++)
            add_instr(i_type(OP_ADDI, 5'(k), 5'd0, 16'(256 + k)));  // must be skipped
        add_instr(i_type(OP_ADDI, 8, 0, 16'd21));
        add_instr(i_type(OP_ADDI, 0, 0, 16'd5));
        add_instr(r_type(FN_ADD, 0, 8, 8, 0));
        add_instr(r_type(FN_ADD, 9, 0, 8, 0));
        add_instr(r_type(FN_OR, 10, 9, 0, 0));
        run_program("pc load", 8'd8);
    endtask

    task automatic test_random();
        for (int p = 0; p < 20; p++)
        begin
            start_program();
            for (int i = 0; i < 24; i++)
                add_instr(random_instr());
            run_program($sformatf("random %0d", p), '0);
        end
    endtask

    // watchdog budget grows as each test starts
    initial
    begin
        int cycles;
        cycles = 0;
        do
        begin
            @(negedge SYS_clk);
            cycles++;
        end
        while (cycles <= budget_cycles);
        $display("watchdog expired after %0d cycles, the pipeline did not drain", cycles);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        SYS_reset     = 1'b1;
        load          = 1'b0;
        pc_val        = '0;
        probe_addr    = '0;
        prog_len      = '0;
        checks        = 0;
        errors        = 0;
        budget_cycles = 0;
        check_reset("reset");
        test_memory_fill();
        test_alu();
        test_dependencies();
        test_load_store();
        test_pc_load();
        test_random();
        check_reset("reset after programs");
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: files.f
+incdir+bench
common/cpu_pkg.sv
logic/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_top.sv
bench/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
